// ==== include/ising_cfg_settings.svh ====
`ifndef ISING_CFG_SETTINGS_SVH
`define ISING_CFG_SETTINGS_SVH

// size of the analog array
`define NUM_SPIN 16

// bits per J, h or sfc coefficient
`define BIT_DATA 4

// J columns packed into one memory row
`define PARALLELISM 2

// width of slot length and slot address counters
`define CNT_W 16

`endif

// ==== design/ising_cfg_pkg.sv ====
`include "ising_cfg_settings.svh"

package ising_cfg_pkg;

    localparam int NUM_SPIN    = `NUM_SPIN;
    localparam int BIT_DATA    = `BIT_DATA;
    localparam int PARALLELISM = `PARALLELISM;
    localparam int CNT_W       = `CNT_W;

    // slot map: J rows first, then h, then sfc
    localparam int J_ROWS   = NUM_SPIN / PARALLELISM;
    localparam int H_SLOT   = J_ROWS;
    localparam int SFC_SLOT = J_ROWS + 1;

    localparam int J_ADDR_W = (J_ROWS > 1) ? $clog2(J_ROWS) : 1;
    localparam int SEL_W    = (PARALLELISM > 1) ? $clog2(PARALLELISM) : 1;

    typedef logic [NUM_SPIN*BIT_DATA-1:0] spin_vec_t;  // one coefficient per spin
    typedef spin_vec_t [PARALLELISM-1:0]  j_row_t;     // column s sits in slice s
    typedef logic [J_ADDR_W-1:0]          j_addr_t;
    typedef logic [CNT_W-1:0]             slot_cnt_t;

endpackage

// ==== design/step_counter.sv ====
`timescale 1ns/100ps

module step_counter
    import ising_cfg_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      en_i,
    input  logic      load_i,     // latch a new limit
    input  slot_cnt_t limit_i,
    input  logic      restart_i,  // back to zero, wins over step
    input  logic      step_i,
    output slot_cnt_t q_o,
    output logic      wrap_o
);

    slot_cnt_t limit_q;
    slot_cnt_t cnt_q;
    logic      step_en;

    assign step_en = en_i & step_i;
    assign wrap_o  = step_en & (cnt_q == limit_q - 1'b1);
    assign q_o     = cnt_q;

    // limit only changes on a configuration load
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            limit_q <= '0;
        end else if (load_i) begin
            limit_q <= limit_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (en_i && restart_i) begin
            cnt_q <= '0;
        end else if (wrap_o) begin
            cnt_q <= '0;  // last count of the period
        end else if (step_en) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

// ==== design/cfg_store.sv ====
`timescale 1ns/100ps

// register array with one write port and a registered read port
module cfg_store #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 1,
    parameter int  AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1
)(
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  word_t         wdata_i,
    input  logic          re_i,
    input  logic [AW-1:0] raddr_i,
    output word_t         rdata_o
);

    word_t         mem_q [DEPTH];
    word_t         rdata_q;
    logic [AW-1:0] w_idx;
    logic [AW-1:0] r_idx;

    // a single-entry store has no address
    assign w_idx = (DEPTH > 1) ? waddr_i : '0;
    assign r_idx = (DEPTH > 1) ? raddr_i : '0;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[w_idx] <= wdata_i;
        end
    end

    // read word stays put between strobes
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (re_i) begin
            rdata_q <= mem_q[r_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== design/analog_cfg.sv ====
`timescale 1ns/100ps

module analog_cfg
    import ising_cfg_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                en_i,
    // counter configuration
    input  logic                cfg_load_i,
    input  slot_cnt_t           slot_len_i,   // cycles per slot, at least 2
    input  slot_cnt_t           trans_num_i,  // slots addresses per run
    input  logic                dt_cfg_start_i,
    // store read side
    output logic                j_ren_o,
    output j_addr_t             j_raddr_o,
    input  j_row_t              j_rdata_i,
    output logic                h_ren_o,
    input  spin_vec_t           h_rdata_i,
    output logic                sfc_ren_o,
    input  spin_vec_t           sfc_rdata_i,
    // macro write side
    output logic [NUM_SPIN-1:0] j_wwl_o,
    output logic                h_wwl_o,
    output logic                sfc_wwl_o,
    output spin_vec_t           wbl_o,
    output logic                dt_cfg_idle_o
);

    slot_cnt_t           delay_q;
    slot_cnt_t           addr_q;
    logic                delay_wrap;
    logic                run_done;
    logic                addr_step;
    logic                busy_q;
    logic                slot_go;
    logic                any_ren;
    logic                is_j;
    logic                is_h;
    logic                is_sfc;
    logic                last_sub;
    logic [SEL_W-1:0]    sel_q;   // column within the current J row
    logic [SEL_W-1:0]    col_q;   // column captured at the last strobe
    logic                j_sel_q;
    logic                h_sel_q;
    logic                sfc_sel_q;
    logic [NUM_SPIN-1:0] j_wwl_nxt;

    // slot class from the address counter
    assign is_j   = (addr_q < slot_cnt_t'(J_ROWS));
    assign is_h   = (addr_q == slot_cnt_t'(H_SLOT));
    assign is_sfc = (addr_q == slot_cnt_t'(SFC_SLOT));

    assign last_sub = (sel_q == SEL_W'(PARALLELISM - 1));

    // first cycle of a slot, not while a restart is pending
    assign slot_go = en_i & busy_q & ~dt_cfg_start_i & (delay_q == '0);

    assign j_ren_o   = slot_go & is_j;
    assign h_ren_o   = slot_go & is_h;
    assign sfc_ren_o = slot_go & is_sfc;
    assign any_ren   = j_ren_o | h_ren_o | sfc_ren_o;

    assign j_raddr_o = j_addr_t'(addr_q);
    assign j_wwl_nxt = NUM_SPIN'(1) << (int'(j_raddr_o) * PARALLELISM + int'(sel_q));

    // row advances after its last column, h and sfc take one slot each
    assign addr_step = delay_wrap & (~is_j | last_sub);

    assign dt_cfg_idle_o = ~busy_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
        end else if (!en_i) begin
            busy_q <= 1'b0;
        end else if (dt_cfg_start_i) begin
            busy_q <= 1'b1;  // also restarts a running sequence
        end else if (run_done) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q <= '0;
        end else if (en_i) begin
            if (dt_cfg_start_i) begin
                sel_q <= '0;
            end else if (delay_wrap && is_j) begin
                sel_q <= last_sub ? '0 : sel_q + 1'b1;
            end
        end
    end

    // registered strobe copies pick the source of the bit lines
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            j_sel_q   <= 1'b0;
            h_sel_q   <= 1'b0;
            sfc_sel_q <= 1'b0;
            col_q     <= '0;
        end else if (en_i && any_ren) begin
            j_sel_q   <= j_ren_o;
            h_sel_q   <= h_ren_o;
            sfc_sel_q <= sfc_ren_o;
            col_q     <= sel_q;
        end
    end

    // store word is loaded on the same edge, so both show up together
    always_comb begin
        if (j_sel_q) begin
            wbl_o = j_rdata_i[col_q];
        end else if (h_sel_q) begin
            wbl_o = h_rdata_i;
        end else if (sfc_sel_q) begin
            wbl_o = sfc_rdata_i;
        end else begin
            wbl_o = '0;  // nothing read since reset
        end
    end

    // word lines rise after the strobe and fall when the slot wraps
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            j_wwl_o   <= '0;
            h_wwl_o   <= 1'b0;
            sfc_wwl_o <= 1'b0;
        end else if (!en_i || dt_cfg_start_i) begin
            j_wwl_o   <= '0;
            h_wwl_o   <= 1'b0;
            sfc_wwl_o <= 1'b0;
        end else if (any_ren) begin
            j_wwl_o   <= j_ren_o ? j_wwl_nxt : '0;
            h_wwl_o   <= h_ren_o;
            sfc_wwl_o <= sfc_ren_o;
        end else if (delay_wrap) begin
            j_wwl_o   <= '0;
            h_wwl_o   <= 1'b0;
            sfc_wwl_o <= 1'b0;
        end
    end

    step_counter u_slot_delay (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .en_i      (en_i),
        .load_i    (cfg_load_i),
        .limit_i   (slot_len_i),
        .restart_i (dt_cfg_start_i),
        .step_i    (busy_q),
        .q_o       (delay_q),
        .wrap_o    (delay_wrap)
    );

    step_counter u_slot_addr (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .en_i      (en_i),
        .load_i    (cfg_load_i),
        .limit_i   (trans_num_i),
        .restart_i (dt_cfg_start_i),
        .step_i    (addr_step),
        .q_o       (addr_q),
        .wrap_o    (run_done)  // last slot finished
    );

endmodule

// ==== design/ising_cfg_top.sv ====
`timescale 1ns/100ps

module ising_cfg_top
    import ising_cfg_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                en_i,
    // counter configuration
    input  logic                cfg_load_i,
    input  slot_cnt_t           slot_len_i,
    input  slot_cnt_t           trans_num_i,
    // host writes
    input  logic                j_we_i,
    input  j_addr_t             j_waddr_i,
    input  j_row_t              j_wdata_i,
    input  logic                h_we_i,
    input  spin_vec_t           h_wdata_i,
    input  logic                sfc_we_i,
    input  spin_vec_t           sfc_wdata_i,
    input  logic                dt_cfg_start_i,
    // analog macro
    output logic [NUM_SPIN-1:0] j_wwl_o,
    output logic                h_wwl_o,
    output logic                sfc_wwl_o,
    output spin_vec_t           wbl_o,
    output logic                dt_cfg_idle_o
);

    logic      j_ren;
    logic      h_ren;
    logic      sfc_ren;
    j_addr_t   j_raddr;
    j_row_t    j_rdata;
    spin_vec_t h_rdata;
    spin_vec_t sfc_rdata;

    cfg_store #(.word_t(j_row_t), .DEPTH(J_ROWS)) u_j_store (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (j_we_i),
        .waddr_i  (j_waddr_i),
        .wdata_i  (j_wdata_i),
        .re_i     (j_ren),
        .raddr_i  (j_raddr),
        .rdata_o  (j_rdata)
    );

    // single-word stores, address tied off
    cfg_store #(.word_t(spin_vec_t), .DEPTH(1)) u_h_store (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (h_we_i),
        .waddr_i  (1'b0),
        .wdata_i  (h_wdata_i),
        .re_i     (h_ren),
        .raddr_i  (1'b0),
        .rdata_o  (h_rdata)
    );

    cfg_store #(.word_t(spin_vec_t), .DEPTH(1)) u_sfc_store (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (sfc_we_i),
        .waddr_i  (1'b0),
        .wdata_i  (sfc_wdata_i),
        .re_i     (sfc_ren),
        .raddr_i  (1'b0),
        .rdata_o  (sfc_rdata)
    );

    analog_cfg u_analog_cfg (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_i           (en_i),
        .cfg_load_i     (cfg_load_i),
        .slot_len_i     (slot_len_i),
        .trans_num_i    (trans_num_i),
        .dt_cfg_start_i (dt_cfg_start_i),
        .j_ren_o        (j_ren),
        .j_raddr_o      (j_raddr),
        .j_rdata_i      (j_rdata),
        .h_ren_o        (h_ren),
        .h_rdata_i      (h_rdata),
        .sfc_ren_o      (sfc_ren),
        .sfc_rdata_i    (sfc_rdata),
        .j_wwl_o        (j_wwl_o),
        .h_wwl_o        (h_wwl_o),
        .sfc_wwl_o      (sfc_wwl_o),
        .wbl_o          (wbl_o),
        .dt_cfg_idle_o  (dt_cfg_idle_o)
    );

endmodule

// ==== tb/ising_cfg_checker.sv ====
`timescale 1ns/100ps

module ising_cfg_checker
    import ising_cfg_pkg::*;
(
    input logic                clk_i,
    input logic                arst_n_i,
    input logic                en_i,
    input slot_cnt_t           slot_len_i,
    input logic                j_ren_i,
    input logic                h_ren_i,
    input logic                sfc_ren_i,
    input logic [NUM_SPIN-1:0] j_wwl_i,
    input logic                h_wwl_i,
    input logic                sfc_wwl_i,
    input logic                idle_i
);

    logic      wl_any;
    slot_cnt_t high_cnt;  // cycles the current word line has been up
    int        fail_class = 0;
    int        fail_hot = 0;
    int        fail_ren = 0;
    int        fail_width = 0;
    int        fail_total;

    assign wl_any     = (|j_wwl_i) | h_wwl_i | sfc_wwl_i;
    assign fail_total = fail_class + fail_hot + fail_ren + fail_width;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            high_cnt <= '0;
        end else begin
            high_cnt <= wl_any ? high_cnt + 1'b1 : '0;
        end
    end

    a_one_class: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({|j_wwl_i, h_wwl_i, sfc_wwl_i}))
        else begin
            $error("J, h and sfc word lines active together");
            fail_class++;
        end

    // a J strobe selects exactly one column line
    a_j_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $past(j_ren_i) ? $onehot(j_wwl_i) : $onehot0(j_wwl_i))
        else begin
            $error("J word lines not one-hot");
            fail_hot++;
        end

    // strobes belong to a running sequence and start a word line pulse
    a_ren_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (j_ren_i || h_ren_i || sfc_ren_i) |=> (wl_any && !idle_i))
        else begin
            $error("read strobe outside a run or without a word line pulse");
            fail_ren++;
        end

    a_wl_width: assert property (@(posedge clk_i) disable iff (!arst_n_i || !en_i)
        $fell(wl_any) |-> (high_cnt == slot_len_i - 1'b1))
        else begin
            $error("word line pulse length is not slot length minus one");
            fail_width++;
        end

endmodule

bind analog_cfg ising_cfg_checker u_checker (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .en_i       (en_i),
    .slot_len_i (slot_len_i),
    .j_ren_i    (j_ren_o),
    .h_ren_i    (h_ren_o),
    .sfc_ren_i  (sfc_ren_o),
    .j_wwl_i    (j_wwl_o),
    .h_wwl_i    (h_wwl_o),
    .sfc_wwl_i  (sfc_wwl_o),
    .idle_i     (dt_cfg_idle_o)
);

// ==== tb/ising_cfg_monitor.sv ====
`timescale 1ns/100ps

module ising_cfg_monitor
    import ising_cfg_pkg::*;
(
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                j_we_i,
    input  j_addr_t             j_waddr_i,
    input  j_row_t              j_wdata_i,
    input  logic                h_we_i,
    input  spin_vec_t           h_wdata_i,
    input  logic                sfc_we_i,
    input  spin_vec_t           sfc_wdata_i,
    input  logic                dt_cfg_start_i,
    input  logic [NUM_SPIN-1:0] j_wwl_i,
    input  logic                h_wwl_i,
    input  logic                sfc_wwl_i,
    input  spin_vec_t           wbl_i,
    input  logic                dt_cfg_idle_i,
    output int                  err_cnt_o,
    output int                  chk_cnt_o
);

    localparam int WL_W = NUM_SPIN + 2;  // {sfc, h, j}

    j_row_t          j_shadow [J_ROWS];
    spin_vec_t       h_shadow;
    spin_vec_t       sfc_shadow;
    logic [WL_W-1:0] wl_now;
    logic [WL_W-1:0] wl_prev = '0;
    string           test_name = "none";
    int              exp_writes = -1;  // -1 for a run that gets cut short
    int              exp_cycles = 0;
    int              wr_idx = 0;
    int              run_cycles = 0;
    logic            running = 1'b0;
    int              write_errs = 0;
    int              write_chks = 0;
    int              quiet_errs = 0;
    int              quiet_chks = 0;

    assign wl_now    = {sfc_wwl_i, h_wwl_i, j_wwl_i};
    assign err_cnt_o = write_errs + quiet_errs;
    assign chk_cnt_o = write_chks + quiet_chks;

    // slot k: J columns in index order, then h, then sfc
    function automatic void predict_write(input int k, output logic [WL_W-1:0] wl,
                                          output spin_vec_t data);
        wl   = '0;
        data = '0;
        if (k < WL_W) begin
            wl = WL_W'(1) << k;
        end
        if (k < NUM_SPIN) begin
            data = j_shadow[j_addr_t'(k / PARALLELISM)][SEL_W'(k % PARALLELISM)];
        end else if (k == NUM_SPIN) begin
            data = h_shadow;
        end else if (k == NUM_SPIN + 1) begin
            data = sfc_shadow;
        end
    endfunction

    task automatic set_test(input string name, input int n_writes, input int n_cycles);
        test_name  = name;
        exp_writes = n_writes;
        exp_cycles = n_cycles;
    endtask

    task automatic check_quiet(input string name, input logic check_wbl);
        quiet_chks++;
        if (wl_now !== '0 || dt_cfg_idle_i !== 1'b1 || (check_wbl && wbl_i !== '0)) begin
            quiet_errs++;
            $display("mismatch test %s idle state: expected wl 0 idle 1, actual wl %h idle %b wbl %h",
                     name, wl_now, dt_cfg_idle_i, wbl_i);
        end
    endtask

    always @(negedge clk_i) begin  // host writes land on the next rising edge
        if (j_we_i) j_shadow[j_waddr_i] = j_wdata_i;
        if (h_we_i) h_shadow = h_wdata_i;
        if (sfc_we_i) sfc_shadow = sfc_wdata_i;
    end

    always @(negedge clk_i) begin : watch_outputs
        logic [WL_W-1:0] exp_wl;
        spin_vec_t       exp_data;
        if (!arst_n_i) begin
            running = 1'b0;
            wl_prev = '0;
        end else begin
            if (dt_cfg_start_i) begin
                running    = 1'b1;  // also a restart
                wr_idx     = 0;
                run_cycles = 0;
            end else if (running && !dt_cfg_idle_i) begin
                run_cycles++;
            end else if (running) begin
                running = 1'b0;
                if (exp_writes >= 0) begin
                    write_chks += 2;
                    if (wr_idx != exp_writes) begin
                        write_errs++;
                        $display("mismatch test %s write count: expected %0d actual %0d",
                                 test_name, exp_writes, wr_idx);
                    end
                    if (run_cycles != exp_cycles) begin
                        write_errs++;
                        $display("mismatch test %s run cycles: expected %0d actual %0d",
                                 test_name, exp_cycles, run_cycles);
                    end
                end
            end
            if (wl_now != '0 && wl_prev == '0) begin
                predict_write(wr_idx, exp_wl, exp_data);
                write_chks++;
                if (wl_now !== exp_wl || wbl_i !== exp_data) begin
                    write_errs++;
                    $display("mismatch test %s write %0d: expected wl %h wbl %h, actual wl %h wbl %h",
                             test_name, wr_idx, exp_wl, exp_data, wl_now, wbl_i);
                end
                wr_idx++;
            end
            wl_prev = wl_now;
        end
    end

endmodule

// ==== tb/ising_cfg_tb.sv ====
`timescale 1ns/100ps

module ising_cfg_tb
    import ising_cfg_pkg::*;
();

    localparam int     PERIOD     = 100;
    localparam int     W_MAX      = 9;
    localparam int     RB_W       = $bits(j_row_t);
    // slot lengths of all runs: 2, 3, random, short 3, aborted 4, restart 4
    localparam int     RUN_SUM    = (NUM_SPIN + 2) * (2 + 3 + W_MAX + 3 + 4 + 4);
    localparam int     OVERHEAD   = 16 + 6 * (J_ROWS + 20);
    localparam longint TIMEOUT_NS = 2 * (RUN_SUM + OVERHEAD) * PERIOD;

    logic                clk;
    logic                arst_n;
    logic                en;
    logic                cfg_load;
    slot_cnt_t           slot_len;
    slot_cnt_t           trans_num;
    logic                j_we;
    j_addr_t             j_waddr;
    j_row_t              j_wdata;
    logic                h_we;
    spin_vec_t           h_wdata;
    logic                sfc_we;
    spin_vec_t           sfc_wdata;
    logic                start;
    logic [NUM_SPIN-1:0] j_wwl;
    logic                h_wwl;
    logic                sfc_wwl;
    spin_vec_t           wbl;
    logic                idle;
    int                  mon_errs;
    int                  mon_chks;
    int                  assert_errs;
    int                  w_rand;

    ising_cfg_top dut_i (
        .clk_i(clk), .arst_n_i(arst_n), .en_i(en),
        .cfg_load_i(cfg_load), .slot_len_i(slot_len), .trans_num_i(trans_num),
        .j_we_i(j_we), .j_waddr_i(j_waddr), .j_wdata_i(j_wdata),
        .h_we_i(h_we), .h_wdata_i(h_wdata), .sfc_we_i(sfc_we), .sfc_wdata_i(sfc_wdata),
        .dt_cfg_start_i(start), .j_wwl_o(j_wwl), .h_wwl_o(h_wwl), .sfc_wwl_o(sfc_wwl),
        .wbl_o(wbl), .dt_cfg_idle_o(idle)
    );

    ising_cfg_monitor u_monitor (
        .clk_i(clk), .arst_n_i(arst_n),
        .j_we_i(j_we), .j_waddr_i(j_waddr), .j_wdata_i(j_wdata),
        .h_we_i(h_we), .h_wdata_i(h_wdata), .sfc_we_i(sfc_we), .sfc_wdata_i(sfc_wdata),
        .dt_cfg_start_i(start), .j_wwl_i(j_wwl), .h_wwl_i(h_wwl), .sfc_wwl_i(sfc_wwl),
        .wbl_i(wbl), .dt_cfg_idle_i(idle), .err_cnt_o(mon_errs), .chk_cnt_o(mon_chks)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin  // watchdog
        #(TIMEOUT_NS);
        $display("timeout: the sequencer did not return to idle within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic next_drive_slot();  // 10 ns after the next rising edge
        @(posedge clk);
        #10;
    endtask

    function automatic logic [RB_W-1:0] rand_bits();
        logic [RB_W-1:0] v;
        v = '0;
        for (int i = 0; i < (RB_W + 31) / 32; i++) begin
            v = (v << 32) | RB_W'($urandom);
        end
        return v;
    endfunction

    function automatic int expected_writes(input int trans);
        if (trans <= J_ROWS) begin
            return trans * PARALLELISM;
        end else if (trans == J_ROWS + 1) begin
            return NUM_SPIN + 1;
        end
        return NUM_SPIN + 2;
    endfunction

    task automatic fill_stores();
        for (int r = 0; r < J_ROWS; r++) begin
            next_drive_slot();
            j_we    = 1'b1;
            j_waddr = j_addr_t'(r);
            j_wdata = j_row_t'(rand_bits());
        end
        next_drive_slot();
        j_we      = 1'b0;
        h_we      = 1'b1;
        h_wdata   = spin_vec_t'(rand_bits());
        sfc_we    = 1'b1;
        sfc_wdata = spin_vec_t'(rand_bits());
        next_drive_slot();
        h_we   = 1'b0;
        sfc_we = 1'b0;
    endtask

    task automatic load_config(input int w, input int trans);
        next_drive_slot();
        cfg_load  = 1'b1;
        slot_len  = slot_cnt_t'(w);
        trans_num = slot_cnt_t'(trans);
        next_drive_slot();
        cfg_load = 1'b0;
    endtask

    task automatic start_and_wait();
        next_drive_slot();
        start = 1'b1;
        next_drive_slot();
        start = 1'b0;
        wait (idle);  // busy since the last edge
        repeat (2) @(posedge clk);
    endtask

    task automatic do_run(input string name, input int w, input int trans);
        fill_stores();
        load_config(w, trans);
        u_monitor.set_test(name, expected_writes(trans), expected_writes(trans) * w);
        start_and_wait();
    endtask

    initial begin
        void'($urandom(32'hcadd_b214));
        arst_n = 1'b0;
        en = 1'b1;
        cfg_load = 1'b0;
        slot_len = '0;
        trans_num = '0;
        j_we = 1'b0;
        j_waddr = '0;
        j_wdata = '0;
        h_we = 1'b0;
        h_wdata = '0;
        sfc_we = 1'b0;
        sfc_wdata = '0;
        start = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        arst_n = 1'b1;
        @(negedge clk);
        u_monitor.check_quiet("reset", 1'b1);

        do_run("full_w2", 2, J_ROWS + 2);
        do_run("full_w3", 3, J_ROWS + 2);
        w_rand = 2 + int'($urandom % 8);
        do_run("full_wrand", w_rand, J_ROWS + 2);
        do_run("short_run", 3, 3);

        // drop enable while the fourth word line is up
        fill_stores();
        load_config(4, J_ROWS + 2);
        u_monitor.set_test("en_drop", -1, 0);
        next_drive_slot();
        start = 1'b1;
        next_drive_slot();
        start = 1'b0;
        repeat (14) @(posedge clk);
        #10;
        en = 1'b0;
        @(posedge clk);
        @(negedge clk);
        u_monitor.check_quiet("en_drop", 1'b0);
        repeat (3) next_drive_slot();
        en = 1'b1;
        u_monitor.set_test("en_restart", NUM_SPIN + 2, (NUM_SPIN + 2) * 4);
        start_and_wait();

        repeat (4) @(posedge clk);
        assert_errs = dut_i.u_analog_cfg.u_checker.fail_total;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 mon_chks, mon_errs, assert_errs);
        if (mon_errs == 0 && assert_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== ising_cfg.f ====
+incdir+include
design/ising_cfg_pkg.sv
design/step_counter.sv
design/cfg_store.sv
design/analog_cfg.sv
design/ising_cfg_top.sv
tb/ising_cfg_checker.sv
tb/ising_cfg_monitor.sv
tb/ising_cfg_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ising_cfg_tb
RTL_TOP   ?= ising_cfg_top
FILELIST  ?= ising_cfg.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= design/ising_cfg_pkg.sv design/step_counter.sv design/cfg_store.sv \
             design/analog_cfg.sv design/ising_cfg_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) +incdir+include $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
